// File: source/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // banked layout, bank field sits above the word index
    localparam int BANK_SEL_W = 2;
    localparam int BANK_LSB   = 10;
    localparam int WORD_IDX_W = 8; // word index occupies address bits 9:2
    localparam int NUM_BANKS  = 1 << BANK_SEL_W;

    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [DATA_W-1:0]     word_t;
    typedef logic [1:0]            acc_size_t;
    typedef logic [BANK_SEL_W-1:0] bank_sel_t;
    typedef logic [WORD_IDX_W-1:0] word_idx_t;
    typedef logic [NUM_BANKS-1:0]  bank_onehot_t;

    // access size codes, code 3 is handled as a full word
    localparam acc_size_t SIZE_BYTE = 2'd0;
    localparam acc_size_t SIZE_HALF = 2'd1;
    localparam acc_size_t SIZE_WORD = 2'd2;

endpackage

`default_nettype wire

// File: source/store_merge.sv
`default_nettype none

module store_merge
(
    input  wire mem_pkg::word_t       old_word,
    input  wire logic [1:0]           lane,
    input  wire mem_pkg::acc_size_t   size,
    input  wire mem_pkg::word_t       wdata,
    output mem_pkg::word_t            merge_word
);

    mem_pkg::word_t byte_word;
    mem_pkg::word_t half_word;

    // replace one byte lane, lane 0 is bits 7:0
    always_comb
    begin
        case (lane)
            2'd0:    byte_word = {old_word[31:8], wdata[7:0]};
            2'd1:    byte_word = {old_word[31:16], wdata[7:0], old_word[7:0]};
            2'd2:    byte_word = {old_word[31:24], wdata[7:0], old_word[15:0]};
            default: byte_word = {wdata[7:0], old_word[23:0]};
        endcase
    end

    // address bit 0 plays no part in a half store
    assign half_word = lane[1] ? {wdata[15:0], old_word[15:0]}
                               : {old_word[31:16], wdata[15:0]};

    always_comb
    begin
        case (size)
            mem_pkg::SIZE_BYTE: merge_word = byte_word;
            mem_pkg::SIZE_HALF: merge_word = half_word;
            mem_pkg::SIZE_WORD: merge_word = wdata;
            default:            merge_word = wdata; // code 3 acts as a word
        endcase
    end

endmodule

`default_nettype wire

// File: source/load_align.sv
`default_nettype none

module load_align
(
    input  wire mem_pkg::word_t       old_word,
    input  wire logic [1:0]           lane,
    input  wire mem_pkg::acc_size_t   size,
    input  wire logic                 zero_ext,
    output mem_pkg::word_t            rdata
);

    logic [7:0]     lane_byte;
    logic [15:0]    lane_half;
    mem_pkg::word_t byte_ext;
    mem_pkg::word_t half_ext;

    always_comb
    begin
        case (lane)
            2'd0:    lane_byte = old_word[7:0];
            2'd1:    lane_byte = old_word[15:8];
            2'd2:    lane_byte = old_word[23:16];
            default: lane_byte = old_word[31:24];
        endcase
    end

    assign lane_half = lane[1] ? old_word[31:16] : old_word[15:0];

    // zero_ext selects unsigned loads, otherwise the top bit is replicated
    assign byte_ext = zero_ext ? {24'd0, lane_byte}
                               : {{24{lane_byte[7]}}, lane_byte};
    assign half_ext = zero_ext ? {16'd0, lane_half}
                               : {{16{lane_half[15]}}, lane_half};

    always_comb
    begin
        case (size)
            mem_pkg::SIZE_BYTE: rdata = byte_ext;
            mem_pkg::SIZE_HALF: rdata = half_ext;
            mem_pkg::SIZE_WORD: rdata = old_word;
            default:            rdata = old_word;
        endcase
    end

endmodule

`default_nettype wire

// File: source/bank_array.sv
`default_nettype none

module bank_array
(
    input  wire                       clk,
    input  wire                       arst_n,

    input  wire mem_pkg::addr_t       instr_addr,
    output mem_pkg::word_t            instr,

    input  wire mem_pkg::addr_t       data_addr,
    input  wire logic                 w_en,
    input  wire mem_pkg::word_t       merge_word,
    output mem_pkg::word_t            old_word
);

    mem_pkg::bank_sel_t    instr_bank;
    mem_pkg::word_idx_t    instr_idx;
    mem_pkg::bank_sel_t    data_bank;
    mem_pkg::word_idx_t    data_idx;
    mem_pkg::bank_onehot_t data_onehot; // decoded bank of the data port

    // per-bank read words, picked by bank number below
    mem_pkg::word_t instr_bank_word [mem_pkg::NUM_BANKS];
    mem_pkg::word_t data_bank_word  [mem_pkg::NUM_BANKS];

    // address fields, bits above the bank field are ignored
    assign instr_bank = instr_addr[mem_pkg::BANK_LSB +: mem_pkg::BANK_SEL_W];
    assign data_bank  = data_addr[mem_pkg::BANK_LSB +: mem_pkg::BANK_SEL_W];
    assign instr_idx  =
        instr_addr[mem_pkg::BANK_LSB-mem_pkg::WORD_IDX_W +: mem_pkg::WORD_IDX_W];
    assign data_idx   =
        data_addr[mem_pkg::BANK_LSB-mem_pkg::WORD_IDX_W +: mem_pkg::WORD_IDX_W];

    always_comb
    begin
        data_onehot = '0;
        for (int b = 0; b < mem_pkg::NUM_BANKS; b++)
        begin
            if (data_bank == mem_pkg::bank_sel_t'(b))
            begin
                data_onehot[b] = 1'b1;
            end
        end
    end

    for (genvar b = 0; b < mem_pkg::NUM_BANKS; b++)
    begin : g_bank
        mem_pkg::word_t bank_mem [2**mem_pkg::WORD_IDX_W];
        logic           bank_we;

        assign bank_we = w_en && data_onehot[b];

        // writes are held off while reset is asserted, contents are kept
        always_ff @(posedge clk)
        begin
            if (arst_n && bank_we)
            begin
                bank_mem[data_idx] <= merge_word;
            end
        end

        assign instr_bank_word[b] = bank_mem[instr_idx];
        assign data_bank_word[b]  = bank_mem[data_idx];
    end

    // both read ports are combinational
    assign instr    = instr_bank_word[instr_bank];
    assign old_word = data_bank_word[data_bank];

endmodule

`default_nettype wire

// File: source/mem_subsystem.sv
`default_nettype none

module mem_subsystem
(
    input  wire                       clk,
    input  wire                       arst_n,

    // instruction fetch port, read only
    input  wire mem_pkg::addr_t       instr_addr,
    output mem_pkg::word_t            instr,

    // load/store port
    input  wire mem_pkg::addr_t       data_addr,
    input  wire mem_pkg::acc_size_t   size,
    input  wire logic                 zero_ext,
    input  wire logic                 w_en,
    input  wire mem_pkg::word_t       wdata,
    output mem_pkg::word_t            rdata
);

    mem_pkg::word_t old_word;   // stored word at data_addr, read combinationally
    mem_pkg::word_t merge_word; // word written back on a store

    bank_array u_bank_array
    (
        .clk        (clk),
        .arst_n     (arst_n),
        .instr_addr (instr_addr),
        .instr      (instr),
        .data_addr  (data_addr),
        .w_en       (w_en),
        .merge_word (merge_word),
        .old_word   (old_word)
    );

    // narrow stores are read-modify-write, so the merge works on the word just read
    store_merge u_store_merge
    (
        .old_word   (old_word),
        .lane       (data_addr[1:0]),
        .size       (size),
        .wdata      (wdata),
        .merge_word (merge_word)
    );

    load_align u_load_align
    (
        .old_word   (old_word),
        .lane       (data_addr[1:0]),
        .size       (size),
        .zero_ext   (zero_ext),
        .rdata      (rdata)
    );

endmodule

`default_nettype wire

// File: sim/mem_subsystem_sva.sv
`default_nettype none

module mem_subsystem_sva
(
    input  wire                        clk,
    input  wire                        arst_n,
    input  wire logic                  w_en,
    input  wire mem_pkg::bank_onehot_t data_onehot,
    input  wire mem_pkg::word_t        merge_word,
    input  wire mem_pkg::addr_t        data_addr
);

    timeunit 1ns;
    timeprecision 1ps;

    // exactly one bank may take a write
    property p_onehot_write_sel;
        @(posedge clk) disable iff (!arst_n)
            w_en |-> $onehot(data_onehot);
    endproperty

    property p_known_merge_word;
        @(posedge clk) disable iff (!arst_n)
            w_en |-> !$isunknown(merge_word);
    endproperty

    property p_known_data_addr;
        @(posedge clk) disable iff (!arst_n)
            w_en |-> !$isunknown(data_addr);
    endproperty

    a_onehot_write_sel: assert property (p_onehot_write_sel)
        else $error("bank write select is not one-hot while w_en is high");

    a_known_merge_word: assert property (p_known_merge_word)
        else $error("merge_word has unknown bits while w_en is high");

    a_known_data_addr: assert property (p_known_data_addr)
        else $error("data_addr has unknown bits while w_en is high");

endmodule

bind bank_array mem_subsystem_sva u_mem_subsystem_sva
(
    .clk         (clk),
    .arst_n      (arst_n),
    .w_en        (w_en),
    .data_onehot (data_onehot),
    .merge_word  (merge_word),
    .data_addr   (data_addr)
);

`default_nettype wire

// File: sim/tb_mem_subsystem.sv
`default_nettype none

module tb_mem_subsystem;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD    = 40;
    localparam int DRIVE_DELAY   = 2;
    localparam int SETTLE_DELAY  = 5;
    localparam int RESET_CYCLES  = 8;
    localparam int TEST_CYCLES   = 600; // generous budget, the tests need well under half
    localparam int WATCHDOG_TIME = (TEST_CYCLES + 50) * CLK_PERIOD;

    logic               clk;
    logic               arst_n;
    mem_pkg::addr_t     instr_addr;
    mem_pkg::word_t     instr;
    mem_pkg::addr_t     data_addr;
    mem_pkg::acc_size_t size;
    logic               zero_ext;
    logic               w_en;
    mem_pkg::word_t     wdata;
    mem_pkg::word_t     rdata;

    mem_pkg::word_t ref_mem [int]; // reference contents keyed by address bits 11:2
    int seed      = 1;
    int checks    = 0;
    int errors    = 0;
    int tests_run = 0;

    mem_subsystem u_mem_subsystem
    (
        .clk        (clk),
        .arst_n     (arst_n),
        .instr_addr (instr_addr),
        .instr      (instr),
        .data_addr  (data_addr),
        .size       (size),
        .zero_ext   (zero_ext),
        .w_en       (w_en),
        .wdata      (wdata),
        .rdata      (rdata)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    function automatic int key_of(mem_pkg::addr_t addr);
        return int'(addr[11:2]); // higher bits alias every 4 KiB
    endfunction

    // stored word after a store, following the lane rules
    function automatic mem_pkg::word_t expect_merge(mem_pkg::word_t old, mem_pkg::addr_t addr,
                                                    mem_pkg::acc_size_t sz, mem_pkg::word_t data);
        mem_pkg::word_t mask;
        int             shift;
        if (sz == mem_pkg::SIZE_BYTE)
        begin
            shift = 8 * addr[1:0];
            mask  = 32'h0000_00ff << shift;
        end
        else if (sz == mem_pkg::SIZE_HALF)
        begin
            shift = 16 * addr[1]; // bit 0 plays no part in a half access
            mask  = 32'h0000_ffff << shift;
        end
        else
        begin
            shift = 0;
            mask  = 32'hffff_ffff;
        end
        return (old & ~mask) | ((data << shift) & mask);
    endfunction

    function automatic mem_pkg::word_t expect_load(mem_pkg::word_t stored, mem_pkg::addr_t addr,
                                                   mem_pkg::acc_size_t sz, logic zext);
        mem_pkg::word_t raw;
        int             width;
        if (sz == mem_pkg::SIZE_BYTE)
        begin
            width = 8;
            raw   = (stored >> (8 * addr[1:0])) & 32'h0000_00ff;
        end
        else if (sz == mem_pkg::SIZE_HALF)
        begin
            width = 16;
            raw   = (stored >> (16 * addr[1])) & 32'h0000_ffff;
        end
        else
        begin
            return stored;
        end
        if (!zext && raw[width-1])
        begin
            raw = raw | (32'hffff_ffff << width);
        end
        return raw;
    endfunction

    task automatic next_slot();
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    task automatic check_value(string what, mem_pkg::word_t got, mem_pkg::word_t exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s returned %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic report_test(string name, int start_errors);
        tests_run++;
        $display("test %-14s %s (%0d errors)", name,
                 (errors == start_errors) ? "passed" : "failed", errors - start_errors);
    endtask

    // one write cycle, the model follows the same store
    task automatic store(mem_pkg::addr_t addr, mem_pkg::acc_size_t sz, mem_pkg::word_t data);
        mem_pkg::word_t old;
        int             key;
        key = key_of(addr);
        old = ref_mem.exists(key) ? ref_mem[key] : '0;
        next_slot();
        data_addr = addr;
        size      = sz;
        wdata     = data;
        w_en      = 1'b1;
        next_slot();
        w_en         = 1'b0;
        ref_mem[key] = expect_merge(old, addr, sz, data);
    endtask

    task automatic check_load(string what, mem_pkg::addr_t addr, mem_pkg::acc_size_t sz,
                              logic zext);
        int key;
        key = key_of(addr);
        next_slot();
        data_addr = addr;
        size      = sz;
        zero_ext  = zext;
        w_en      = 1'b0;
        #(SETTLE_DELAY);
        if (!ref_mem.exists(key))
        begin
            errors++;
            $display("%s reads address %h, which no test has written", what, addr);
        end
        else
        begin
            check_value(what, rdata, expect_load(ref_mem[key], addr, sz, zext));
        end
    endtask

    task automatic test_word_access();
        mem_pkg::addr_t addrs [16];
        int             start_errors;
        start_errors = errors;
        for (int i = 0; i < 16; i++)
        begin
            addrs[i] = ($random(seed) & 32'hffff_f3fc) | ((i % 4) << mem_pkg::BANK_LSB);
            store(addrs[i], mem_pkg::SIZE_WORD, $random(seed));
        end
        for (int i = 0; i < 16; i++)
        begin
            check_load("word load", addrs[i], mem_pkg::SIZE_WORD, 1'b0);
        end
        report_test("word_access", start_errors);
    endtask

    task automatic test_byte_access();
        mem_pkg::addr_t base;
        mem_pkg::addr_t addr;
        mem_pkg::word_t noise;
        logic [7:0]     value;
        int             start_errors;
        start_errors = errors;
        base         = 32'h0000_0840; // bank 2
        for (int i = 0; i < 8; i++)
        begin
            addr  = base + (i % 4);
            value = (i < 4) ? 8'hc3 : 8'h5a; // top bit set in the first round, clear after
            noise = $random(seed);
            store(base, mem_pkg::SIZE_WORD, 32'h1234_5678);
            store(addr, mem_pkg::SIZE_BYTE, {noise[31:8], value});
            check_load("word after byte store", base, mem_pkg::SIZE_WORD, 1'b0);
            check_load("signed byte load", addr, mem_pkg::SIZE_BYTE, 1'b0);
            check_load("unsigned byte load", addr, mem_pkg::SIZE_BYTE, 1'b1);
        end
        report_test("byte_access", start_errors);
    endtask

    task automatic test_half_access();
        mem_pkg::addr_t base;
        mem_pkg::addr_t addr;
        mem_pkg::word_t noise;
        logic [15:0]    value;
        int             start_errors;
        start_errors = errors;
        base         = 32'h0000_0c80; // bank 3
        for (int i = 0; i < 4; i++)
        begin
            addr  = base + 2 * (i / 2) + (i % 2); // odd i sets address bit 0
            value = (i % 2 == 1) ? 16'h7ffe : 16'h8001;
            noise = $random(seed);
            store(base, mem_pkg::SIZE_WORD, 32'h89ab_cdef);
            store(addr, mem_pkg::SIZE_HALF, {noise[31:16], value});
            check_load("word after half store", base, mem_pkg::SIZE_WORD, 1'b0);
            check_load("signed half load", addr, mem_pkg::SIZE_HALF, 1'b0);
            check_load("unsigned half load", addr ^ 32'h1, mem_pkg::SIZE_HALF, 1'b1);
        end
        report_test("half_access", start_errors);
    endtask

    task automatic test_instr_port();
        mem_pkg::addr_t addr;
        int             start_errors;
        start_errors = errors;
        for (int i = 0; i < 4; i++)
        begin
            addr = ((i % 2 == 1) ? 32'h0000_0c00 : 32'h0000_0000) + 32'h40 * (i + 1);
            store(addr, mem_pkg::SIZE_WORD, $random(seed));
            next_slot();
            instr_addr = addr;
            data_addr  = addr ^ 32'h0000_0800; // data port parked in another bank
            #(SETTLE_DELAY);
            check_value("instruction fetch", instr, ref_mem[key_of(addr)]);
            next_slot();
            instr_addr = addr + 32'h0000_1000;
            #(SETTLE_DELAY);
            check_value("instruction fetch 4 KiB above", instr, ref_mem[key_of(addr)]);
        end
        report_test("instr_port", start_errors);
    endtask

    task automatic test_write_gating();
        mem_pkg::addr_t addr;
        int             start_errors;
        start_errors = errors;
        addr         = 32'h0000_0408; // bank 1
        store(addr, mem_pkg::SIZE_WORD, 32'h5a5a_0f0f);
        next_slot();
        data_addr = addr;
        size      = mem_pkg::SIZE_WORD;
        wdata     = 32'h1111_2222;
        w_en      = 1'b0;
        check_load("word after idle cycle", addr, mem_pkg::SIZE_WORD, 1'b0);
        // attempt a write across two edges with reset held low
        next_slot();
        arst_n    = 1'b0;
        data_addr = addr;
        size      = mem_pkg::SIZE_WORD;
        wdata     = 32'ha5a5_f0f0;
        w_en      = 1'b1;
        next_slot();
        next_slot();
        w_en   = 1'b0;
        arst_n = 1'b1;
        check_load("word after write under reset", addr, mem_pkg::SIZE_WORD, 1'b0);
        report_test("write_gating", start_errors);
    endtask

    initial
    begin
        arst_n     = 1'b0;
        instr_addr = '0;
        data_addr  = '0;
        size       = mem_pkg::SIZE_WORD;
        zero_ext   = 1'b0;
        w_en       = 1'b0;
        wdata      = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        arst_n = 1'b1;

        test_word_access();
        test_byte_access();
        test_half_access();
        test_instr_port();
        test_write_gating();

        $display("tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0)
        begin
            $display("Everything OK");
        end
        else
        begin
            $display("Something failed");
        end
        $finish;
    end

    initial
    begin
        #(WATCHDOG_TIME);
        $display("watchdog expired at %0t ns before the tests completed", $time);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
source/mem_pkg.sv
source/store_merge.sv
source/load_align.sv
source/bank_array.sv
source/mem_subsystem.sv
sim/mem_subsystem_sva.sv
sim/tb_mem_subsystem.sv
